//--- source/axi_pkg.sv
/*
 * AXI4 widths and the legal transfer size
 * Burst and response enums, AXI channel structs
 * Outstanding request entry and the write and read response halves
 */
`default_nettype none

package axi_pkg;

  // *********************************************************************
  // Widths
  // *********************************************************************
  localparam int AxiAddrWidth = 16;
  localparam int AxiDataWidth = 32;
  localparam int AxiIdWidth   = 4;
  localparam int AxiLenWidth  = 8;

  // Only 4-byte beats are supported
  localparam logic [2:0] AxiSizeWord = 3'b010;

  // Burst type and response codes as coded on the bus
  typedef enum logic [1:0] {
    AXI_FIXED = 2'b00,
    AXI_INCR  = 2'b01,
    AXI_WRAP  = 2'b10
  } axi_burst_t;

  typedef enum logic [1:0] {
    AXI_OKAY   = 2'b00,
    AXI_EXOKAY = 2'b01,
    AXI_SLVERR = 2'b10,
    AXI_DECERR = 2'b11
  } axi_resp_t;

  // *********************************************************************
  // Channel structs
  // *********************************************************************
  // Master driven fields of AW, W, B, AR and R
  typedef struct packed {
    logic                    awvalid;
    logic [AxiAddrWidth-1:0] awaddr;
    logic [AxiIdWidth-1:0]   awid;
    logic [AxiLenWidth-1:0]  awlen;
    logic [2:0]              awsize;
    axi_burst_t              awburst;
    logic                    wvalid;
    logic [AxiDataWidth-1:0] wdata;
    logic                    wlast;
    logic                    bready;
    logic                    arvalid;
    logic [AxiAddrWidth-1:0] araddr;
    logic [AxiIdWidth-1:0]   arid;
    logic [AxiLenWidth-1:0]  arlen;
    logic [2:0]              arsize;
    axi_burst_t              arburst;
    logic                    rready;
  } s_axi_mosi_t;

  // Slave driven fields
  typedef struct packed {
    logic                    awready;
    logic                    wready;
    logic                    bvalid;
    axi_resp_t               bresp;
    logic [AxiIdWidth-1:0]   bid;
    logic                    arready;
    logic                    rvalid;
    logic [AxiDataWidth-1:0] rdata;
    axi_resp_t               rresp;
    logic [AxiIdWidth-1:0]   rid;
    logic                    rlast;
  } s_axi_miso_t;

  // Write half of the slave side
  typedef struct packed {
    logic                    awready;
    logic                    wready;
    logic                    bvalid;
    axi_resp_t               bresp;
    logic [AxiIdWidth-1:0]   bid;
  } s_axi_wr_resp_t;

  // Read half of the slave side
  typedef struct packed {
    logic                    arready;
    logic                    rvalid;
    logic [AxiDataWidth-1:0] rdata;
    axi_resp_t               rresp;
    logic [AxiIdWidth-1:0]   rid;
    logic                    rlast;
  } s_axi_rd_resp_t;

  // One queued request, error set when the checks failed
  typedef struct packed {
    logic [AxiAddrWidth-1:0] addr;
    logic [AxiIdWidth-1:0]   id;
    logic [AxiLenWidth-1:0]  alen;
    logic                    error;
  } s_ot_entry_t;

endpackage

`default_nettype wire

//--- source/noc_pkg.sv
/*
 * NoC endpoint constants, window address map and region enum
 * Flit structs and the window address decoder
 */
`default_nettype none

package noc_pkg;

  // *********************************************************************
  // Virtual channels and buffering
  // *********************************************************************
  localparam int NumVirtChn    = 3;
  localparam int VcWidth       = 2;
  localparam int FlitDataWidth = 32;
  localparam int VcBuffSlots   = 4;
  localparam int OtSlots       = 2;

  // Address map, one word per VC with a fixed stride
  localparam int              MmAddrWidth  = 16;
  localparam logic [15:0]     WrWindowBase = 16'h1000;
  localparam logic [15:0]     RdWindowBase = 16'h2000;
  localparam int              VcStride     = 8;

  typedef enum logic [1:0] {
    REG_NONE  = 2'b00,
    REG_WR_VC = 2'b01,
    REG_RD_VC = 2'b10
  } mm_region_t;

  // Flit towards the router
  typedef struct packed {
    logic                     valid;
    logic [VcWidth-1:0]       vc_id;
    logic [FlitDataWidth-1:0] data;
  } s_flit_out_t;

  // Flit from the router
  typedef struct packed {
    logic                     valid;
    logic [VcWidth-1:0]       vc_id;
    logic [FlitDataWidth-1:0] data;
  } s_flit_in_t;

  // Decoded region and VC of an address
  typedef struct packed {
    mm_region_t         region;
    logic [VcWidth-1:0] vc;
  } s_mm_dec_t;

  // Exact match on base plus stride times n only
  // Anything else falls to REG_NONE
  function automatic s_mm_dec_t mm_decode(input logic [MmAddrWidth-1:0] addr);
    s_mm_dec_t dec;
    dec.region = REG_NONE;
    dec.vc     = '0;
    for (int n = 0; n < NumVirtChn; n++) begin
      if (addr == WrWindowBase + MmAddrWidth'(VcStride * n)) begin
        dec.region = REG_WR_VC;
        dec.vc     = VcWidth'(n);
      end
      if (addr == RdWindowBase + MmAddrWidth'(VcStride * n)) begin
        dec.region = REG_RD_VC;
        dec.vc     = VcWidth'(n);
      end
    end
    return dec;
  endfunction

endpackage

`default_nettype wire

//--- source/ot_fifo.sv
/*
 * Circular buffer FIFO with the head word shown on the output
 * Used for outstanding requests and for the VC receive buffers
 */
`timescale 1ns/1ns
`default_nettype none

module ot_fifo #(
  parameter int SLOTS = 2,
  parameter int WIDTH = 8
) (
  input  logic             clk_axi,
  input  logic             arst_axi,
  input  logic             write_i,
  input  logic             read_i,
  input  logic [WIDTH-1:0] data_i,
  output logic [WIDTH-1:0] data_o,
  output logic             full_o,
  output logic             empty_o
);

  // Storage, pointers and occupancy
  logic [WIDTH-1:0]         mem [SLOTS];
  logic [$clog2(SLOTS)-1:0] wr_ptr;
  logic [$clog2(SLOTS)-1:0] rd_ptr;
  logic [$clog2(SLOTS):0]   count;
  logic                     do_write;
  logic                     do_read;

  assign full_o   = (count == SLOTS);
  assign empty_o  = (count == 0);
  // Push when full or pop when empty is dropped
  assign do_write = write_i && !full_o;
  assign do_read  = read_i && !empty_o;

  // Head is visible without a read cycle
  assign data_o = mem[rd_ptr];

  always_ff @(posedge clk_axi) begin
    if (do_write) begin
      mem[wr_ptr] <= data_i;
    end
  end

  always_ff @(posedge clk_axi or posedge arst_axi) begin
    if (arst_axi) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else begin
      // Pointers wrap at the last slot
      if (do_write) begin
        wr_ptr <= (wr_ptr == SLOTS - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (do_read) begin
        rd_ptr <= (rd_ptr == SLOTS - 1) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leaves the count alone
      case ({do_write, do_read})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- source/axi_wr_ctrl.sv
/*
 * AXI write path, AW check and outstanding queue
 * W beats streamed out as flits, registered B response
 */
`timescale 1ns/1ns
`default_nettype none

module axi_wr_ctrl
  import axi_pkg::*;
  import noc_pkg::*;
(
  input  logic           clk_axi,
  input  logic           arst_axi,
  input  s_axi_mosi_t    axi_mosi_i,
  output s_axi_wr_resp_t aw_o,
  output s_flit_out_t    flit_out_o,
  input  logic           flit_out_ready_i
);

  // Outstanding queue
  s_ot_entry_t ot_in;
  s_ot_entry_t head;
  logic        ot_full;
  logic        ot_empty;
  logic        ot_pop;

  // Decode of incoming AW and of the head entry
  s_mm_dec_t   aw_dec;
  s_mm_dec_t   head_dec;
  logic        aw_ok;

  // Data phase and response
  logic        w_active;
  logic        w_hs;
  logic        bvalid_q;
  axi_resp_t   bresp_q;
  logic [AxiIdWidth-1:0] bid_q;

  // *********************************************************************
  // Address channel
  // *********************************************************************
  assign aw_dec = mm_decode(axi_mosi_i.awaddr);
  // INCR, word size and a write window hit
  assign aw_ok  = (axi_mosi_i.awburst == AXI_INCR) &&
                  (axi_mosi_i.awsize == AxiSizeWord) &&
                  (aw_dec.region == REG_WR_VC);

  // Bad requests still take a slot so they get a SLVERR
  assign ot_in.addr  = axi_mosi_i.awaddr;
  assign ot_in.id    = axi_mosi_i.awid;
  assign ot_in.alen  = axi_mosi_i.awlen;
  assign ot_in.error = !aw_ok;

  ot_fifo #(
    .SLOTS (OtSlots),
    .WIDTH ($bits(s_ot_entry_t))
  ) u_ot_wr (
    .clk_axi  (clk_axi),
    .arst_axi (arst_axi),
    .write_i  (axi_mosi_i.awvalid && aw_o.awready),
    .read_i   (ot_pop),
    .data_i   (ot_in),
    .data_o   (head),
    .full_o   (ot_full),
    .empty_o  (ot_empty)
  );

  // *********************************************************************
  // Data channel and flit output
  // *********************************************************************
  assign head_dec = mm_decode(head.addr);
  // Beats only move while a head exists and B is not pending
  assign w_active = !ot_empty && !bvalid_q;

  always_comb begin
    aw_o.awready     = !ot_full;
    aw_o.wready      = 1'b0;
    flit_out_o.valid = 1'b0;
    flit_out_o.vc_id = head_dec.vc;
    flit_out_o.data  = axi_mosi_i.wdata;
    if (w_active) begin
      if (head.error) begin
        // Sink the beats of a rejected burst
        aw_o.wready = 1'b1;
      end
      else begin
        // Router back-pressure goes straight to W
        aw_o.wready      = flit_out_ready_i;
        flit_out_o.valid = axi_mosi_i.wvalid;
      end
    end
    aw_o.bvalid = bvalid_q;
    aw_o.bresp  = bresp_q;
    aw_o.bid    = bid_q;
  end

  assign w_hs   = axi_mosi_i.wvalid && aw_o.wready;
  // Head leaves the queue on the last beat
  assign ot_pop = w_hs && axi_mosi_i.wlast;

  // *********************************************************************
  // Response channel
  // *********************************************************************
  always_ff @(posedge clk_axi or posedge arst_axi) begin
    if (arst_axi) begin
      bvalid_q <= 1'b0;
    end
    else begin
      bvalid_q <= ot_pop || (bvalid_q && !axi_mosi_i.bready);
    end
  end

  // Captured with the last beat, held until bready
  always_ff @(posedge clk_axi) begin
    if (ot_pop) begin
      bresp_q <= head.error ? AXI_SLVERR : AXI_OKAY;
      bid_q   <= head.id;
    end
  end

endmodule

`default_nettype wire

//--- source/vc_rx_buffers.sv
/*
 * Per-VC receive FIFOs for inbound flits
 * Read port muxed by the selected VC
 */
`timescale 1ns/1ns
`default_nettype none

module vc_rx_buffers
  import noc_pkg::*;
(
  input  logic                     clk_axi,
  input  logic                     arst_axi,
  input  s_flit_in_t               flit_in_i,
  output logic                     flit_in_ready_o,
  input  logic [VcWidth-1:0]       rd_vc_i,
  input  logic                     rd_pop_i,
  output logic [FlitDataWidth-1:0] rd_data_o,
  output logic                     rd_empty_o
);

  logic [NumVirtChn-1:0]                    vc_full;
  logic [NumVirtChn-1:0]                    vc_empty;
  logic [NumVirtChn-1:0]                    vc_push;
  logic [NumVirtChn-1:0]                    vc_pop;
  logic [NumVirtChn-1:0][FlitDataWidth-1:0] vc_head;

  always_comb begin
    // Unknown VC index reads as an empty channel
    flit_in_ready_o = 1'b1;
    rd_data_o       = '0;
    rd_empty_o      = 1'b1;
    for (int i = 0; i < NumVirtChn; i++) begin
      // Inbound steering, only into a FIFO with room
      vc_push[i] = flit_in_i.valid && (flit_in_i.vc_id == VcWidth'(i)) && !vc_full[i];
      // Pop goes to the selected VC only
      vc_pop[i]  = rd_pop_i && (rd_vc_i == VcWidth'(i));
      if (flit_in_i.vc_id == VcWidth'(i)) begin
        flit_in_ready_o = !vc_full[i];
      end
      if (rd_vc_i == VcWidth'(i)) begin
        rd_data_o  = vc_head[i];
        rd_empty_o = vc_empty[i];
      end
    end
  end

  // One buffer per VC
  for (genvar g = 0; g < NumVirtChn; g++) begin : gen_vc_fifo
    ot_fifo #(
      .SLOTS (VcBuffSlots),
      .WIDTH (FlitDataWidth)
    ) u_vc_fifo (
      .clk_axi  (clk_axi),
      .arst_axi (arst_axi),
      .write_i  (vc_push[g]),
      .read_i   (vc_pop[g]),
      .data_i   (flit_in_i.data),
      .data_o   (vc_head[g]),
      .full_o   (vc_full[g]),
      .empty_o  (vc_empty[g])
    );
  end

endmodule

`default_nettype wire

//--- source/axi_rd_ctrl.sv
/*
 * AXI read path, AR check and outstanding queue
 * R beats drained from the selected VC buffer, error beat for bad requests
 */
`timescale 1ns/1ns
`default_nettype none

module axi_rd_ctrl
  import axi_pkg::*;
  import noc_pkg::*;
(
  input  logic                     clk_axi,
  input  logic                     arst_axi,
  input  s_axi_mosi_t              axi_mosi_i,
  output s_axi_rd_resp_t           ar_o,
  output logic [VcWidth-1:0]       rd_vc_o,
  output logic                     rd_pop_o,
  input  logic [FlitDataWidth-1:0] rd_data_i,
  input  logic                     rd_empty_i
);

  // Outstanding queue
  s_ot_entry_t ot_in;
  s_ot_entry_t head;
  logic        ot_full;
  logic        ot_empty;
  logic        ot_pop;

  // Decode of incoming AR and of the head entry
  s_mm_dec_t   ar_dec;
  s_mm_dec_t   head_dec;
  logic        ar_ok;

  // Beat tracking
  logic [AxiLenWidth-1:0] beat_cnt;
  logic                   r_hs;

  // *********************************************************************
  // Address channel
  // *********************************************************************
  assign ar_dec = mm_decode(axi_mosi_i.araddr);
  assign ar_ok  = (axi_mosi_i.arburst == AXI_INCR) &&
                  (axi_mosi_i.arsize == AxiSizeWord) &&
                  (ar_dec.region == REG_RD_VC);

  // Failed checks are queued too and answered with one error beat
  assign ot_in.addr  = axi_mosi_i.araddr;
  assign ot_in.id    = axi_mosi_i.arid;
  assign ot_in.alen  = axi_mosi_i.arlen;
  assign ot_in.error = !ar_ok;

  ot_fifo #(
    .SLOTS (OtSlots),
    .WIDTH ($bits(s_ot_entry_t))
  ) u_ot_rd (
    .clk_axi  (clk_axi),
    .arst_axi (arst_axi),
    .write_i  (axi_mosi_i.arvalid && ar_o.arready),
    .read_i   (ot_pop),
    .data_i   (ot_in),
    .data_o   (head),
    .full_o   (ot_full),
    .empty_o  (ot_empty)
  );

  // *********************************************************************
  // Data channel
  // *********************************************************************
  assign head_dec = mm_decode(head.addr);
  assign rd_vc_o  = head_dec.vc;

  always_comb begin
    ar_o.arready = !ot_full;
    ar_o.rid     = ot_empty ? '0 : head.id;
    ar_o.rvalid  = 1'b0;
    ar_o.rdata   = '0;
    ar_o.rresp   = AXI_OKAY;
    ar_o.rlast   = 1'b0;
    if (!ot_empty) begin
      if (head.error) begin
        // Single beat, zero data
        ar_o.rvalid = 1'b1;
        ar_o.rresp  = AXI_SLVERR;
        ar_o.rlast  = 1'b1;
      end
      else begin
        // Beat ready as soon as the buffer holds a flit
        // Head stays put until popped so R holds under stall
        ar_o.rvalid = !rd_empty_i;
        ar_o.rdata  = rd_data_i;
        ar_o.rlast  = !rd_empty_i && (beat_cnt == head.alen);
      end
    end
  end

  assign r_hs     = ar_o.rvalid && axi_mosi_i.rready;
  // Buffer is drained only by good beats
  assign rd_pop_o = r_hs && !head.error;
  assign ot_pop   = r_hs && ar_o.rlast;

  // Beat count of the head entry, cleared at burst end
  always_ff @(posedge clk_axi or posedge arst_axi) begin
    if (arst_axi) begin
      beat_cnt <= '0;
    end
    else if (r_hs) begin
      beat_cnt <= ar_o.rlast ? '0 : beat_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- source/axi_slave_top.sv
/*
 * AXI4 slave front end of the NoC endpoint
 * Write controller, VC receive buffers and read controller
 */
`timescale 1ns/1ns
`default_nettype none

module axi_slave_top
  import axi_pkg::*;
  import noc_pkg::*;
(
  input  logic        clk_axi,
  input  logic        arst_axi,
  input  s_axi_mosi_t axi_mosi_i,
  output s_axi_miso_t axi_miso_o,
  output s_flit_out_t flit_out_o,
  input  logic        flit_out_ready_i,
  input  s_flit_in_t  flit_in_i,
  output logic        flit_in_ready_o
);

  s_axi_wr_resp_t           wr_resp;
  s_axi_rd_resp_t           rd_resp;
  logic [VcWidth-1:0]       rd_vc;
  logic                     rd_pop;
  logic [FlitDataWidth-1:0] rd_data;
  logic                     rd_empty;

  // Merge both response halves onto the slave side bundle
  assign axi_miso_o.awready = wr_resp.awready;
  assign axi_miso_o.wready  = wr_resp.wready;
  assign axi_miso_o.bvalid  = wr_resp.bvalid;
  assign axi_miso_o.bresp   = wr_resp.bresp;
  assign axi_miso_o.bid     = wr_resp.bid;
  assign axi_miso_o.arready = rd_resp.arready;
  assign axi_miso_o.rvalid  = rd_resp.rvalid;
  assign axi_miso_o.rdata   = rd_resp.rdata;
  assign axi_miso_o.rresp   = rd_resp.rresp;
  assign axi_miso_o.rid     = rd_resp.rid;
  assign axi_miso_o.rlast   = rd_resp.rlast;

  // PE writes become outgoing flits
  axi_wr_ctrl u_wr_ctrl (
    .clk_axi          (clk_axi),
    .arst_axi         (arst_axi),
    .axi_mosi_i       (axi_mosi_i),
    .aw_o             (wr_resp),
    .flit_out_o       (flit_out_o),
    .flit_out_ready_i (flit_out_ready_i)
  );

  // Inbound flits parked per VC
  vc_rx_buffers u_rx_buffers (
    .clk_axi         (clk_axi),
    .arst_axi        (arst_axi),
    .flit_in_i       (flit_in_i),
    .flit_in_ready_o (flit_in_ready_o),
    .rd_vc_i         (rd_vc),
    .rd_pop_i        (rd_pop),
    .rd_data_o       (rd_data),
    .rd_empty_o      (rd_empty)
  );

  // PE reads drain the buffers
  axi_rd_ctrl u_rd_ctrl (
    .clk_axi    (clk_axi),
    .arst_axi   (arst_axi),
    .axi_mosi_i (axi_mosi_i),
    .ar_o       (rd_resp),
    .rd_vc_o    (rd_vc),
    .rd_pop_o   (rd_pop),
    .rd_data_i  (rd_data),
    .rd_empty_i (rd_empty)
  );

endmodule

`default_nettype wire

//--- test/axi_slave_props.sv
/*
 * Protocol assertions bound to the AXI slave top level
 * B and R hold under back-pressure, rlast framing, wready during B
 */
`timescale 1ns/1ns
`default_nettype none

module axi_slave_props
  import axi_pkg::*;
(
  input logic        clk_axi,
  input logic        arst_axi,
  input s_axi_mosi_t axi_mosi_i,
  input s_axi_miso_t axi_miso_i
);

  // Sticky violation flag
  logic prop_fail = 1'b0;

  // *******************************************************************
  // Response channels
  // *******************************************************************
  // B payload frozen until the master takes it
  a_b_hold: assert property (@(posedge clk_axi) disable iff (arst_axi)
    axi_miso_i.bvalid && !axi_mosi_i.bready |=>
      axi_miso_i.bvalid && $stable(axi_miso_i.bid) && $stable(axi_miso_i.bresp))
    else begin
      $error("B response changed or dropped before bready");
      prop_fail = 1'b1;
    end

  // R beat frozen while rready is low
  a_r_hold: assert property (@(posedge clk_axi) disable iff (arst_axi)
    axi_miso_i.rvalid && !axi_mosi_i.rready |=>
      axi_miso_i.rvalid && $stable(axi_miso_i.rdata))
    else begin
      $error("R beat changed or dropped before rready");
      prop_fail = 1'b1;
    end

  a_rlast_valid: assert property (@(posedge clk_axi) disable iff (arst_axi)
    axi_miso_i.rlast |-> axi_miso_i.rvalid)
    else begin
      $error("rlast high without rvalid");
      prop_fail = 1'b1;
    end

  // *******************************************************************
  // Write data path
  // *******************************************************************
  // No W beat accepted while B is pending
  a_no_w_in_b: assert property (@(posedge clk_axi) disable iff (arst_axi)
    axi_miso_i.bvalid |-> !axi_miso_i.wready)
    else begin
      $error("wready high while bvalid is high");
      prop_fail = 1'b1;
    end

endmodule

bind axi_slave_top axi_slave_props u_props (
  .clk_axi    (clk_axi),
  .arst_axi   (arst_axi),
  .axi_mosi_i (axi_mosi_i),
  .axi_miso_i (axi_miso_o)
);

`default_nettype wire

//--- test/tb_axi_slave.sv
/*
 * Testbench for the AXI4 slave NoC front end
 * Write, read, error and back-pressure stimulus with reference queues
 * Concurrent checks of every flit, B and R transfer against the queues
 */
`timescale 1ns/1ns
`default_nettype none

module tb_axi_slave
  import axi_pkg::*;
  import noc_pkg::*;
();

  localparam int QDepth    = 256;
  localparam int MaxCycles = 3000;

  // Expected transfers
  typedef struct packed {
    logic [VcWidth-1:0]       vc_id;
    logic [FlitDataWidth-1:0] data;
  } s_exp_flit_t;

  typedef struct packed {
    axi_resp_t             resp;
    logic [AxiIdWidth-1:0] id;
  } s_exp_b_t;

  typedef struct packed {
    logic [AxiDataWidth-1:0] data;
    axi_resp_t               resp;
    logic [AxiIdWidth-1:0]   id;
    logic                    last;
  } s_exp_r_t;

  logic        clk_axi = 1'b0;
  logic        arst_axi;
  s_axi_mosi_t axi_mosi;
  s_axi_miso_t axi_miso;
  s_flit_out_t flit_out;
  logic        flit_out_ready;
  s_flit_in_t  flit_in;
  logic        flit_in_ready;

  // Reference queues, written by stimulus, read index moves on each transfer
  s_exp_flit_t exp_flit [QDepth];
  s_exp_b_t    exp_b [QDepth];
  s_exp_r_t    exp_r [QDepth];
  int flit_wr = 0;
  int flit_rd = 0;
  int b_wr = 0;
  int b_rd = 0;
  int r_wr = 0;
  int r_rd = 0;
  // Model of each receive buffer fill level
  int rx_count [NumVirtChn] = '{default: 0};
  logic [VcWidth-1:0] rd_vc_sel = '0;
  int cycles = 0;

  logic flit_hs;
  logic w_hs;
  logic b_hs;
  logic r_hs;
  logic rx_push;
  logic rx_pop;

  assign flit_hs = flit_out.valid && flit_out_ready;
  assign w_hs    = axi_mosi.wvalid && axi_miso.wready;
  assign b_hs    = axi_miso.bvalid && axi_mosi.bready;
  assign r_hs    = axi_miso.rvalid && axi_mosi.rready;
  assign rx_push = flit_in.valid && flit_in_ready;
  // Only expected good beats drain a buffer
  assign rx_pop  = r_hs && (exp_r[r_rd].resp == AXI_OKAY);

  axi_slave_top dut_i (
    .clk_axi          (clk_axi),
    .arst_axi         (arst_axi),
    .axi_mosi_i       (axi_mosi),
    .axi_miso_o       (axi_miso),
    .flit_out_o       (flit_out),
    .flit_out_ready_i (flit_out_ready),
    .flit_in_i        (flit_in),
    .flit_in_ready_o  (flit_in_ready)
  );

  always #10 clk_axi = ~clk_axi;

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string msg);
    fail_run($sformatf("MISMATCH at %0t ns: %s", $time, msg));
  endtask

  // *******************************************************************
  // Reference tracking and watchdog
  // *******************************************************************
  always @(posedge clk_axi) begin
    cycles <= cycles + 1;
    if (flit_hs) flit_rd <= flit_rd + 1;
    if (b_hs) b_rd <= b_rd + 1;
    if (r_hs) r_rd <= r_rd + 1;
    for (int v = 0; v < NumVirtChn; v++) begin
      rx_count[v] <= rx_count[v]
                   + ((rx_push && flit_in.vc_id == VcWidth'(v)) ? 1 : 0)
                   - ((rx_pop && rd_vc_sel == VcWidth'(v)) ? 1 : 0);
    end
    if (cycles >= MaxCycles) fail_run("Timeout, the run did not finish in time");
  end

  // Violation in the bound protocol checker
  always @(negedge clk_axi) begin
    if (dut_i.u_props.prop_fail) fail_run("A bound protocol assertion failed");
  end

  // *******************************************************************
  // Transfer checks
  // *******************************************************************
  a_flit_known: assert property (@(posedge clk_axi) disable iff (arst_axi)
    flit_hs |-> flit_rd < flit_wr)
    else fail_run("Flit sent with no expected write beat behind it");

  a_flit_value: assert property (@(posedge clk_axi) disable iff (arst_axi)
    flit_hs && flit_rd < flit_wr |->
      flit_out.vc_id == exp_flit[flit_rd].vc_id && flit_out.data == exp_flit[flit_rd].data)
    else report_mismatch($sformatf("flit vc %0d data %h, expected vc %0d data %h",
      $sampled(flit_out.vc_id), $sampled(flit_out.data),
      exp_flit[$sampled(flit_rd)].vc_id, exp_flit[$sampled(flit_rd)].data));

  // W beats of a good burst only move with the router ready
  a_w_stall: assert property (@(posedge clk_axi) disable iff (arst_axi)
    w_hs && !flit_out_ready |-> !flit_out.valid)
    else fail_run("W beat accepted while the router was not ready");

  a_b_known: assert property (@(posedge clk_axi) disable iff (arst_axi)
    b_hs |-> b_rd < b_wr)
    else fail_run("B response with no write outstanding");

  a_b_value: assert property (@(posedge clk_axi) disable iff (arst_axi)
    b_hs && b_rd < b_wr |->
      axi_miso.bresp == exp_b[b_rd].resp && axi_miso.bid == exp_b[b_rd].id)
    else report_mismatch($sformatf("bresp %0d bid %0d, expected bresp %0d bid %0d",
      $sampled(axi_miso.bresp), $sampled(axi_miso.bid),
      exp_b[$sampled(b_rd)].resp, exp_b[$sampled(b_rd)].id));

  a_r_known: assert property (@(posedge clk_axi) disable iff (arst_axi)
    r_hs |-> r_rd < r_wr)
    else fail_run("R beat with no read beat expected");

  a_r_value: assert property (@(posedge clk_axi) disable iff (arst_axi)
    r_hs && r_rd < r_wr |->
      axi_miso.rdata == exp_r[r_rd].data && axi_miso.rresp == exp_r[r_rd].resp &&
      axi_miso.rid == exp_r[r_rd].id && axi_miso.rlast == exp_r[r_rd].last)
    else report_mismatch($sformatf("R data %h resp %0d id %0d last %b, expected %h %0d %0d %b",
      $sampled(axi_miso.rdata), $sampled(axi_miso.rresp), $sampled(axi_miso.rid),
      $sampled(axi_miso.rlast), exp_r[$sampled(r_rd)].data, exp_r[$sampled(r_rd)].resp,
      exp_r[$sampled(r_rd)].id, exp_r[$sampled(r_rd)].last));

  // Inbound ready follows the fill level of the addressed VC
  a_rx_ready: assert property (@(posedge clk_axi) disable iff (arst_axi)
    flit_in_ready == (rx_count[flit_in.vc_id] < VcBuffSlots))
    else report_mismatch($sformatf("flit_in_ready %b for VC %0d holding %0d flits",
      $sampled(flit_in_ready), $sampled(flit_in.vc_id), rx_count[$sampled(flit_in.vc_id)]));

  // Idle outputs right after reset release
  a_reset_state: assert property (@(posedge clk_axi)
    $fell(arst_axi) |-> !axi_miso.bvalid && !axi_miso.rvalid && !axi_miso.wready &&
      !flit_out.valid && axi_miso.awready && axi_miso.arready && flit_in_ready)
    else fail_run("Outputs not in their idle state after reset");

  // *******************************************************************
  // Stimulus
  // *******************************************************************
  // One AW, its W beats and the B response; stall holds the router off beat 0
  task automatic write_burst(input logic [AxiAddrWidth-1:0] addr, input axi_burst_t burst,
                             input logic ok, input logic [VcWidth-1:0] vc, input int stall);
    logic [AxiIdWidth-1:0]   id;
    logic [AxiLenWidth-1:0]  len;
    logic [AxiDataWidth-1:0] data;
    id  = AxiIdWidth'($urandom);
    len = AxiLenWidth'($urandom_range(0, 3));
    exp_b[b_wr] = '{resp: ok ? AXI_OKAY : AXI_SLVERR, id: id};
    b_wr++;
    @(negedge clk_axi);
    axi_mosi.awvalid = 1'b1;
    axi_mosi.awaddr  = addr;
    axi_mosi.awid    = id;
    axi_mosi.awlen   = len;
    axi_mosi.awsize  = AxiSizeWord;
    axi_mosi.awburst = burst;
    #1;
    while (!axi_miso.awready) begin
      @(negedge clk_axi);
      #1;
    end
    @(negedge clk_axi);
    axi_mosi.awvalid = 1'b0;
    flit_out_ready   = (stall == 0);
    for (int beat = 0; beat <= int'(len); beat++) begin
      data = $urandom;
      // Only good bursts leave flits behind
      if (ok) begin
        exp_flit[flit_wr] = '{vc_id: vc, data: data};
        flit_wr++;
      end
      axi_mosi.wvalid = 1'b1;
      axi_mosi.wdata  = data;
      axi_mosi.wlast  = (beat == int'(len));
      if (beat == 0) repeat (stall) @(negedge clk_axi);
      flit_out_ready = 1'b1;
      #1;
      while (!axi_miso.wready) begin
        @(negedge clk_axi);
        #1;
      end
      @(negedge clk_axi);
    end
    axi_mosi.wvalid = 1'b0;
    axi_mosi.wlast  = 1'b0;
    // Late bready leaves B waiting for a few cycles
    repeat ($urandom_range(0, 2)) @(negedge clk_axi);
    axi_mosi.bready = 1'b1;
    #1;
    while (!axi_miso.bvalid) begin
      @(negedge clk_axi);
      #1;
    end
    @(negedge clk_axi);
    axi_mosi.bready = 1'b0;
  endtask

  // Fills VC vc with len+1 flits for a good read, then drains it over R
  task automatic read_burst(input logic [AxiAddrWidth-1:0] addr, input logic ok,
                            input logic [VcWidth-1:0] vc, input int len);
    logic [AxiIdWidth-1:0]   id;
    logic [AxiDataWidth-1:0] data;
    id = AxiIdWidth'($urandom);
    if (ok) begin
      for (int beat = 0; beat <= len; beat++) begin
        data = $urandom;
        exp_r[r_wr] = '{data: data, resp: AXI_OKAY, id: id, last: (beat == len)};
        r_wr++;
        @(negedge clk_axi);
        flit_in.valid = 1'b1;
        flit_in.vc_id = vc;
        flit_in.data  = data;
        #1;
        while (!flit_in_ready) begin
          @(negedge clk_axi);
          #1;
        end
      end
      @(negedge clk_axi);
      flit_in.valid = 1'b0;
      // Ready seen for the filled VC, then for its neighbour
      @(negedge clk_axi);
      flit_in.vc_id = VcWidth'((int'(vc) + 1) % NumVirtChn);
      @(negedge clk_axi);
      flit_in.vc_id = vc;
    end
    else begin
      exp_r[r_wr] = '{data: '0, resp: AXI_SLVERR, id: id, last: 1'b1};
      r_wr++;
    end
    rd_vc_sel = vc;
    @(negedge clk_axi);
    axi_mosi.arvalid = 1'b1;
    axi_mosi.araddr  = addr;
    axi_mosi.arid    = id;
    axi_mosi.arlen   = AxiLenWidth'(len);
    axi_mosi.arsize  = AxiSizeWord;
    axi_mosi.arburst = AXI_INCR;
    #1;
    while (!axi_miso.arready) begin
      @(negedge clk_axi);
      #1;
    end
    @(negedge clk_axi);
    axi_mosi.arvalid = 1'b0;
    repeat ($urandom_range(0, 2)) @(negedge clk_axi);
    axi_mosi.rready = 1'b1;
    #1;
    while (!(axi_miso.rvalid && axi_miso.rlast)) begin
      @(negedge clk_axi);
      #1;
    end
    @(negedge clk_axi);
    axi_mosi.rready = 1'b0;
  endtask

  initial begin
    void'($urandom(32'h9b4cdee8));
    axi_mosi       = '0;
    flit_in        = '0;
    flit_out_ready = 1'b1;
    arst_axi       = 1'b1;
    repeat (3) @(negedge clk_axi);
    arst_axi = 1'b0;
    // Good writes to every VC, then one held off by the router
    for (int v = 0; v < NumVirtChn; v++) begin
      write_burst(WrWindowBase + AxiAddrWidth'(VcStride * v), AXI_INCR, 1'b1, VcWidth'(v), 0);
    end
    write_burst(WrWindowBase + AxiAddrWidth'(VcStride), AXI_INCR, 1'b1, 2'd1, 3);
    // Off-grid address, FIXED burst, read window address
    write_burst(WrWindowBase + 16'h4, AXI_INCR, 1'b0, 2'd0, 0);
    write_burst(WrWindowBase, AXI_FIXED, 1'b0, 2'd0, 0);
    write_burst(RdWindowBase, AXI_INCR, 1'b0, 2'd0, 0);
    // VC 0 filled to its depth, the others with random lengths
    read_burst(RdWindowBase, 1'b1, 2'd0, VcBuffSlots - 1);
    for (int v = 1; v < NumVirtChn; v++) begin
      read_burst(RdWindowBase + AxiAddrWidth'(VcStride * v), 1'b1, VcWidth'(v),
                 $urandom_range(0, 3));
    end
    // Rejected reads get one error beat
    read_burst(RdWindowBase + 16'h2, 1'b0, 2'd0, 1);
    read_burst(WrWindowBase, 1'b0, 2'd0, 0);
    repeat (4) @(negedge clk_axi);
    if (flit_rd == flit_wr && b_rd == b_wr && r_rd == r_wr) begin
      $display("all tests passed");
      $finish;
    end
    else begin
      fail_run("Expected transfers still queued at the end of the run");
    end
  end

endmodule

`default_nettype wire

//--- sources.f
source/axi_pkg.sv
source/noc_pkg.sv
source/ot_fifo.sv
source/axi_wr_ctrl.sv
source/vc_rx_buffers.sv
source/axi_rd_ctrl.sv
source/axi_slave_top.sv
test/axi_slave_props.sv
test/tb_axi_slave.sv
